// ==== source/dino_render_config.svh ====
`ifndef DINO_RENDER_CONFIG_SVH
`define DINO_RENDER_CONFIG_SVH

// Visible scan area
`define DR_H_VISIBLE 640
`define DR_V_VISIBLE 480

// Dinosaur window, exclusive bounds, vertical test uses vaddr plus jump
`define DR_DINO_X_MIN 30
`define DR_DINO_X_MAX 75
`define DR_DINO_Y_MIN 155
`define DR_DINO_Y_MAX 248

// Only this band of sprite rows holds any lit pixel
`define DR_DINO_ROW_FIRST 23
`define DR_DINO_ROW_LAST 44

// Cactus window, exclusive bounds
`define DR_CACTUS_Y_MIN 203
`define DR_CACTUS_Y_MAX 250
`define DR_CACTUS_X_BASE 640
`define DR_CACTUS_WIDTH 13

// Scroll offsets of the three obstacle slots
`define DR_SLOT_OFFSET_0 0
`define DR_SLOT_OFFSET_1 250
`define DR_SLOT_OFFSET_2 450

// A slot arms inside the first span and clears once the scroll passes the second
`define DR_SLOT_ARM_SPAN 10
`define DR_SLOT_CLEAR_SPAN 667

`endif

// ==== source/dino_render_pkg.sv ====
package dino_render_pkg;

    // Scan addresses from the video timing
    typedef logic [9:0] scan_coord_t;

    // World scroll position, wide enough for the last slot's clear point
    typedef logic [10:0] scroll_t;

    typedef logic [6:0] jump_t;

    typedef logic [21:0] dino_row_t;
    typedef logic [12:0] cactus_row_t;

    typedef enum logic [1:0] {
        RUN_A,
        RUN_B,
        DEAD
    } dino_frame_e;

    typedef enum logic {
        SLOT_IDLE,
        SLOT_ARMED
    } slot_state_e;

    typedef struct packed {
        logic dino;
        logic slot0;
        logic slot1;
        logic slot2;
    } layer_t;

endpackage

// ==== source/dino_sprite_rom.sv ====
`include "dino_render_config.svh"

module dino_sprite_rom (
    input  dino_render_pkg::dino_frame_e frame,
    input  logic [5:0]                   row,
    input  logic [4:0]                   col,
    output logic                         pix
);

    localparam int BAND_ROWS = `DR_DINO_ROW_LAST - `DR_DINO_ROW_FIRST + 1;

    // Bit 0 of each row is the leftmost sprite column on screen
    localparam dino_render_pkg::dino_row_t RUN_A_ROWS [0:BAND_ROWS-1] = '{
        22'b0011111111000000000000,
        22'b0111111111100000000000,
        22'b0111111101100000000000,
        22'b0111111111100000000000,
        22'b0111111111100000000000,
        22'b0111111111100000000000,
        22'b0000001111100000000000,
        22'b0001111111100000000000,
        22'b0000000111110000000010,
        22'b0000000111111100000010,
        22'b0000011111111110000110,
        22'b0000010111111111001110,
        22'b0000000111111111111110,
        22'b0000000111111111111110,
        22'b0000000011111111111100,
        22'b0000000011111111111000,
        22'b0000000001111111110000,
        22'b0000000000111111100000,
        22'b0000000000110011000000,
        22'b0000000000100110000000,
        22'b0000000000100000000000,
        22'b0000000001100000000000
    };

    localparam dino_render_pkg::dino_row_t RUN_B_ROWS [0:BAND_ROWS-1] = '{
        22'b0011111111000000000000,
        22'b0111111111100000000000,
        22'b0111111101100000000000,
        22'b0111111111100000000000,
        22'b0111111111100000000000,
        22'b0111111111100000000000,
        22'b0000001111100000000000,
        22'b0001111111100000000000,
        22'b0000000111110000000010,
        22'b0000000111111100000010,
        22'b0000011111111110000110,
        22'b0000010111111111001110,
        22'b0000000111111111111110,
        22'b0000000111111111111110,
        22'b0000000011111111111100,
        22'b0000000011111111111000,
        22'b0000000001111111110000,
        22'b0000000000111111100000,
        22'b0000000001100111000000,
        22'b0000000000000011000000,
        22'b0000000000000011000000,
        22'b0000000000000011000000
    };

    // Dead frame fills the open mouth and shows both legs planted
    localparam dino_render_pkg::dino_row_t DEAD_ROWS [0:BAND_ROWS-1] = '{
        22'b0011111111000000000000,
        22'b0111111111100000000000,
        22'b0111111101100000000000,
        22'b0111111111100000000000,
        22'b0111111111100000000000,
        22'b0111111111100000000000,
        22'b0111111111100000000000,
        22'b0001111111100000000000,
        22'b0000000111110000000010,
        22'b0000000111111100000010,
        22'b0000011111111110000110,
        22'b0000010111111111001110,
        22'b0000000111111111111110,
        22'b0000000111111111111110,
        22'b0000000011111111111100,
        22'b0000000011111111111000,
        22'b0000000001111111110000,
        22'b0000000000111111100000,
        22'b0000000000110111000000,
        22'b0000000000100011000000,
        22'b0000000000100001000000,
        22'b0000000001100011000000
    };

    logic                       in_band;
    logic [4:0]                 band_idx;
    dino_render_pkg::dino_row_t row_bits;

    assign in_band  = (row >= `DR_DINO_ROW_FIRST) && (row <= `DR_DINO_ROW_LAST);
    assign band_idx = 5'(row - `DR_DINO_ROW_FIRST);

    always_comb begin
        row_bits = '0;
        if (in_band) begin
            case (frame)
                dino_render_pkg::RUN_B: row_bits = RUN_B_ROWS[band_idx];
                dino_render_pkg::DEAD:  row_bits = DEAD_ROWS[band_idx];
                default:                row_bits = RUN_A_ROWS[band_idx];
            endcase
        end
    end

    assign pix = row_bits[col];

    // The top level must keep the column inside the sprite for any stored row
    always_comb begin
        if (in_band) begin
            assert final (col < $bits(dino_render_pkg::dino_row_t))
                else $error("dino_sprite_rom: column %0d beyond sprite width", col);
        end
    end

endmodule

// ==== source/cactus_sprite_rom.sv ====
module cactus_sprite_rom (
    input  logic [5:0] row,
    input  logic [3:0] col,
    output logic       pix
);

    localparam int CACTUS_ROWS_N = 47;

    localparam dino_render_pkg::cactus_row_t CACTUS_ROWS [0:CACTUS_ROWS_N-1] = '{
        13'b0000000000000,
        13'b0000001000000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0100011100000,
        13'b0110011100000,
        13'b0110011100000,
        13'b0110011100000,
        13'b0110011100000,
        13'b0110011100100,
        13'b0110011100110,
        13'b0110011100110,
        13'b0110011100110,
        13'b0110011100110,
        13'b0110011100110,
        13'b0110011100110,
        13'b0110011100110,
        13'b0110011100110,
        13'b0110011100110,
        13'b0111111100110,
        13'b0111111100110,
        13'b0011111100110,
        13'b0011111100110,
        13'b0001111100110,
        13'b0000011100110,
        13'b0000011111100,
        13'b0000011111100,
        13'b0000011111000,
        13'b0000011111000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000011100000,
        13'b0000111100000
    };

    dino_render_pkg::cactus_row_t row_bits;

    always_comb begin
        row_bits = '0;
        if (row < CACTUS_ROWS_N) begin
            row_bits = CACTUS_ROWS[row];
        end
    end

    // Columns past the narrow cactus read as background
    assign pix = (col < $bits(dino_render_pkg::cactus_row_t)) ? row_bits[col] : 1'b0;

endmodule

// ==== source/obstacle_slot_fsm.sv ====
`include "dino_render_config.svh"

module obstacle_slot_fsm #(
    parameter int SLOT_OFFSET = 0
) (
    input  logic                     clk,
    input  logic                     sys_rst,
    input  logic                     update,
    input  dino_render_pkg::scroll_t scrolladdr,
    output logic                     armed
);

    dino_render_pkg::slot_state_e state;
    dino_render_pkg::slot_state_e state_next;
    logic                         arm_window;
    logic                         clear_reached;

    assign arm_window = (int'(scrolladdr) >= SLOT_OFFSET) &&
                        (int'(scrolladdr) < SLOT_OFFSET + `DR_SLOT_ARM_SPAN);
    assign clear_reached = int'(scrolladdr) > SLOT_OFFSET + `DR_SLOT_CLEAR_SPAN;

    always_comb begin
        state_next = state;
        if (update) begin
            case (state)
                dino_render_pkg::SLOT_IDLE:
                    if (arm_window) state_next = dino_render_pkg::SLOT_ARMED;
                dino_render_pkg::SLOT_ARMED:
                    if (clear_reached) state_next = dino_render_pkg::SLOT_IDLE;
                default:
                    state_next = dino_render_pkg::SLOT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            state <= dino_render_pkg::SLOT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign armed = (state == dino_render_pkg::SLOT_ARMED);

    // Arming needs a visible sample with the scroll inside the arm window
    assert property (@(posedge clk) disable iff (sys_rst)
        $rose(armed) |-> $past(arm_window && update));

endmodule

// ==== source/dino_render.sv ====
`include "dino_render_config.svh"

module dino_render (
    input  logic                         clk,
    input  logic                         sys_rst,
    input  dino_render_pkg::scan_coord_t vaddr,
    input  dino_render_pkg::scan_coord_t haddr,
    input  dino_render_pkg::scroll_t     scrolladdr,
    input  dino_render_pkg::jump_t       jump_pos,
    input  logic                         dinosprite_num,
    input  logic                         game_over,
    input  logic                         game_start_blink,
    input  logic                         score_pixel,
    output logic                         pixel,
    output logic                         collision
);

    localparam int SLOT_OFFSETS [3] = '{`DR_SLOT_OFFSET_0, `DR_SLOT_OFFSET_1, `DR_SLOT_OFFSET_2};

    dino_render_pkg::layer_t      layers;
    dino_render_pkg::layer_t      layers_next;
    dino_render_pkg::dino_frame_e frame;
    logic                         visible;
    logic [10:0]                  dino_y;
    logic [10:0]                  dino_y_off;
    logic [9:0]                   dino_x_off;
    logic [5:0]                   dino_row;
    logic [4:0]                   dino_col;
    logic                         dino_win;
    logic                         dino_pix;
    logic                         cactus_band;
    logic [5:0]                   cactus_row;
    logic [2:0]                   slot_armed;
    logic [2:0]                   slot_hit;

    assign visible = (vaddr < `DR_V_VISIBLE) && (haddr < `DR_H_VISIBLE);

    // Game over shows the dead frame whatever the run frame is
    assign frame = game_over ? dino_render_pkg::DEAD :
                   (dinosprite_num ? dino_render_pkg::RUN_A : dino_render_pkg::RUN_B);

    // Sprite pixels are drawn 2x2, so both offsets are halved
    assign dino_y     = 11'(vaddr) + 11'(jump_pos);
    assign dino_y_off = dino_y - 11'(`DR_DINO_Y_MIN);
    assign dino_x_off = haddr - 10'(`DR_DINO_X_MIN);
    assign dino_row   = dino_y_off[6:1];
    assign dino_col   = dino_x_off[5:1];

    assign dino_win = game_start_blink &&
                      (haddr > `DR_DINO_X_MIN) && (haddr < `DR_DINO_X_MAX) &&
                      (dino_y > `DR_DINO_Y_MIN) && (dino_y < `DR_DINO_Y_MAX) &&
                      (dino_col < $bits(dino_render_pkg::dino_row_t));

    dino_sprite_rom u_dino_rom (
        .frame (frame),
        .row   (dino_win ? dino_row : 6'd0),
        .col   (dino_col),
        .pix   (dino_pix)
    );

    assign cactus_band = (vaddr > `DR_CACTUS_Y_MIN) && (vaddr < `DR_CACTUS_Y_MAX);
    assign cactus_row  = 6'(vaddr - 10'(`DR_CACTUS_Y_MIN));

    for (genvar i = 0; i < 3; i++) begin : g_slot
        logic [11:0] cactus_x;
        logic [3:0]  cactus_col;
        logic        cactus_win;
        logic        cactus_pix;

        // Screen column mapped into the slot's world position
        assign cactus_x   = 12'(haddr) + 12'(scrolladdr) - 12'(SLOT_OFFSETS[i]);
        assign cactus_col = 4'(cactus_x - 12'(`DR_CACTUS_X_BASE + 1));
        assign cactus_win = slot_armed[i] && cactus_band &&
                            (cactus_x > 12'(`DR_CACTUS_X_BASE)) &&
                            (cactus_x <= 12'(`DR_CACTUS_X_BASE + `DR_CACTUS_WIDTH));

        cactus_sprite_rom u_cactus_rom (
            .row (cactus_win ? cactus_row : 6'd0),
            .col (cactus_col),
            .pix (cactus_pix)
        );

        obstacle_slot_fsm #(
            .SLOT_OFFSET (SLOT_OFFSETS[i])
        ) u_slot_fsm (
            .clk        (clk),
            .sys_rst    (sys_rst),
            .update     (visible),
            .scrolladdr (scrolladdr),
            .armed      (slot_armed[i])
        );

        assign slot_hit[i] = cactus_win && cactus_pix;
    end

    always_comb begin
        layers_next = '0;
        if (visible) begin
            layers_next.dino  = dino_win && dino_pix;
            layers_next.slot0 = slot_hit[0];
            layers_next.slot1 = slot_hit[1];
            layers_next.slot2 = slot_hit[2];
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            layers <= '0;
        end else begin
            layers <= layers_next;
        end
    end

    assign pixel     = score_pixel | (|layers);
    assign collision = layers.dino & (layers.slot0 | layers.slot1 | layers.slot2);

    // A collision needs the dinosaur drawn, so the blink was high one sample back
    assert property (@(posedge clk) disable iff (sys_rst)
        $rose(collision) |-> $past(game_start_blink));

    assert property (@(posedge clk) disable iff (sys_rst)
        !$past(visible) |-> (layers == '0));

endmodule

// ==== testbench/render_checker.sv ====
module render_checker (
    input  logic         clk,
    input  logic         check_en,
    input  logic [191:0] test_name,
    input  logic         exp_pixel,
    input  logic         exp_collision,
    input  logic         pixel,
    input  logic         collision,
    output int           checks_done,
    output int           errors
);

    localparam int SAMPLE_DELAY = 1;

    initial begin
        checks_done = 0;
        errors      = 0;
        forever begin
            @(posedge clk);
            // Layers have been registered and the next vector is not driven yet
            #(SAMPLE_DELAY);
            if (check_en) begin
                if ((pixel !== exp_pixel) || (collision !== exp_collision)) begin
                    errors++;
                    $display("MISMATCH %0s: pixel/collision expected %b/%b, actual %b/%b",
                             test_name, exp_pixel, exp_collision, pixel, collision);
                end else begin
                    $display("ok %0s: pixel %b collision %b", test_name, pixel, collision);
                end
                checks_done++;
            end
        end
    end

endmodule

// ==== testbench/tb_dino_render.sv ====
module tb_dino_render;

    localparam int    CLK_HALF      = 4;
    localparam int    RESET_CYCLES  = 8;
    localparam int    DRIVE_DELAY   = 2;
    localparam int    MAX_VECTORS   = 256;
    localparam int    DRAIN_TIMEOUT = 200;
    localparam string PATTERN_FILE  = "testbench/dino_render_patterns.txt";

    typedef struct packed {
        logic [191:0]                 name;
        dino_render_pkg::scan_coord_t vaddr;
        dino_render_pkg::scan_coord_t haddr;
        dino_render_pkg::scroll_t     scroll;
        dino_render_pkg::jump_t       jump;
        logic                         sprite_num;
        logic                         over;
        logic                         blink;
        logic                         score;
        logic                         exp_pixel;
        logic                         exp_collision;
    } vector_t;

    logic                         clk;
    logic                         sys_rst;
    dino_render_pkg::scan_coord_t vaddr;
    dino_render_pkg::scan_coord_t haddr;
    dino_render_pkg::scroll_t     scrolladdr;
    dino_render_pkg::jump_t       jump_pos;
    logic                         dinosprite_num;
    logic                         game_over;
    logic                         game_start_blink;
    logic                         score_pixel;
    logic                         pixel;
    logic                         collision;
    logic                         check_en;
    logic [191:0]                 test_name;
    logic                         exp_pixel;
    logic                         exp_collision;
    int                           checks_done;
    int                           errors;
    logic                         load_ok;
    logic                         timed_out;
    vector_t                      vectors[$];

    dino_render u_dino_render (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .vaddr            (vaddr),
        .haddr            (haddr),
        .scrolladdr       (scrolladdr),
        .jump_pos         (jump_pos),
        .dinosprite_num   (dinosprite_num),
        .game_over        (game_over),
        .game_start_blink (game_start_blink),
        .score_pixel      (score_pixel),
        .pixel            (pixel),
        .collision        (collision)
    );

    render_checker u_render_checker (
        .clk           (clk),
        .check_en      (check_en),
        .test_name     (test_name),
        .exp_pixel     (exp_pixel),
        .exp_collision (exp_collision),
        .pixel         (pixel),
        .collision     (collision),
        .checks_done   (checks_done),
        .errors        (errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    task automatic load_patterns();
        int           fd;
        int           n_read;
        int           guard;
        int           f [10];
        logic [191:0] token;
        logic [1023:0] rest;
        vector_t      vec;
        fd    = $fopen(PATTERN_FILE, "r");
        guard = 0;
        if (fd == 0) begin
            $display("Could not open the pattern file %0s", PATTERN_FILE);
            load_ok = 1'b0;
        end else begin
            while (!$feof(fd) && load_ok && vectors.size() < MAX_VECTORS &&
                   guard < 4 * MAX_VECTORS) begin
                guard++;
                token  = '0;
                n_read = $fscanf(fd, "%s", token);
                if (n_read == 1 && token == "#") begin
                    n_read = $fgets(rest, fd);
                end else if (n_read == 1) begin
                    n_read = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2], f[3],
                                     f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (n_read != 10) begin
                        $display("The pattern line for %0s has missing or bad fields", token);
                        load_ok = 1'b0;
                    end else begin
                        vec.name          = token;
                        vec.vaddr         = dino_render_pkg::scan_coord_t'(f[0]);
                        vec.haddr         = dino_render_pkg::scan_coord_t'(f[1]);
                        vec.scroll        = dino_render_pkg::scroll_t'(f[2]);
                        vec.jump          = dino_render_pkg::jump_t'(f[3]);
                        vec.sprite_num    = f[4][0];
                        vec.over          = f[5][0];
                        vec.blink         = f[6][0];
                        vec.score         = f[7][0];
                        vec.exp_pixel     = f[8][0];
                        vec.exp_collision = f[9][0];
                        vectors.push_back(vec);
                    end
                end
            end
            $fclose(fd);
        end
        if (load_ok && vectors.size() == 0) begin
            $display("The pattern file holds no vectors");
            load_ok = 1'b0;
        end
    endtask

    // The first clock edge already sees reset from time zero
    task automatic apply_vector(input vector_t vec, input int idx);
        sys_rst          = (idx + 1 < RESET_CYCLES);
        vaddr            = vec.vaddr;
        haddr            = vec.haddr;
        scrolladdr       = vec.scroll;
        jump_pos         = vec.jump;
        dinosprite_num   = vec.sprite_num;
        game_over        = vec.over;
        game_start_blink = vec.blink;
        score_pixel      = vec.score;
        test_name        = vec.name;
        exp_pixel        = vec.exp_pixel;
        exp_collision    = vec.exp_collision;
        check_en         = 1'b1;
    endtask

    initial begin
        int drain;
        sys_rst          = 1'b1;
        vaddr            = '0;
        haddr            = '0;
        scrolladdr       = '0;
        jump_pos         = '0;
        dinosprite_num   = 1'b0;
        game_over        = 1'b0;
        game_start_blink = 1'b0;
        score_pixel      = 1'b0;
        check_en         = 1'b0;
        test_name        = '0;
        exp_pixel        = 1'b0;
        exp_collision    = 1'b0;
        load_ok          = 1'b1;
        timed_out        = 1'b0;
        drain            = 0;
        load_patterns();
        for (int i = 0; i < vectors.size(); i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            apply_vector(vectors[i], i);
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        check_en = 1'b0;
        while (checks_done < vectors.size() && drain < DRAIN_TIMEOUT) begin
            @(posedge clk);
            drain++;
        end
        if (checks_done < vectors.size()) begin
            timed_out = 1'b1;
            $display("Timeout: only %0d of %0d vectors were checked within %0d cycles",
                     checks_done, vectors.size(), DRAIN_TIMEOUT);
        end
        $display("Tests: %0d run, %0d passed, %0d failed",
                 checks_done, checks_done - errors, errors);
        if (!load_ok || timed_out || errors != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

// ==== dino_render.f ====
+incdir+source
source/dino_render_pkg.sv
source/dino_sprite_rom.sv
source/cactus_sprite_rom.sv
source/obstacle_slot_fsm.sv
source/dino_render.sv
testbench/render_checker.sv
testbench/tb_dino_render.sv

// ==== Bender.yml ====
package:
  name: dino_render

sources:
  - include_dirs:
      - source
    files:
      - source/dino_render_pkg.sv
      - source/dino_sprite_rom.sv
      - source/cactus_sprite_rom.sv
      - source/obstacle_slot_fsm.sv
      - source/dino_render.sv

  - target: test
    files:
      - testbench/render_checker.sv
      - testbench/tb_dino_render.sv

// ==== testbench/dino_render_patterns.txt ====
# name vaddr haddr scrolladdr jump_pos dinosprite_num game_over game_start_blink score_pixel
# then expected pixel and collision, the first seven vectors are applied while reset is held
rst_hold_0 237 50 5 0 1 0 1 0 0 0
rst_hold_1 237 50 5 0 1 0 1 1 1 0
rst_hold_2 237 50 5 0 1 0 1 0 0 0
rst_hold_3 237 50 5 0 1 0 1 1 1 0
rst_hold_4 237 50 5 0 1 0 1 0 0 0
rst_hold_5 237 50 5 0 1 0 1 1 1 0
rst_hold_6 237 50 5 0 1 0 1 0 0 0
idle_score_hi 214 543 100 0 0 0 0 1 1 0
idle_score_lo 214 543 100 0 0 0 0 0 0 0
run_a_col8 237 46 100 0 1 0 1 0 0 0
run_b_col8 237 46 100 0 0 0 1 0 1 0
run_a_col10 237 50 100 0 1 0 1 0 1 0
run_b_col10 237 50 100 0 0 0 1 0 0 0
dead_over_run_a 237 46 100 0 1 1 1 0 1 0
dead_over_run_b 237 54 100 0 0 1 1 0 0 0
run_b_col12 237 54 100 0 0 0 1 0 1 0
jump_raised 197 50 100 40 1 0 1 0 1 0
jump_none 197 50 100 0 1 0 1 0 0 0
blink_low 237 50 100 0 1 0 0 0 0 0
slot0_arm 100 100 5 0 0 0 0 0 0 0
slot0_lit 214 543 100 0 0 0 0 0 1 0
slot0_unlit 214 544 100 0 0 0 0 0 0 0
slot0_disarm 100 100 700 0 0 0 0 0 0 0
slot0_gone 214 543 100 0 0 0 0 0 0 0
slot1_arm 100 100 255 0 0 0 0 0 0 0
slot1_lit 214 593 300 0 0 0 0 0 1 0
collide_hit 237 50 846 0 1 0 1 0 1 1
collide_unlit_dino 237 50 846 0 0 0 1 0 1 0
hidden_arm_h 100 640 455 0 0 0 0 0 0 0
hidden_arm_v 480 100 455 0 0 0 0 0 0 0
hidden_cactus 214 700 193 0 0 0 0 0 0 0
hidden_probe 214 593 500 0 0 0 0 0 0 0
slot2_arm 100 100 455 0 0 0 0 0 0 0
slot2_lit 214 593 500 0 0 0 0 0 1 0
